//--- Bender.yml
package:
  name: mul_apb

sources:
  # RTL, package first
  - files:
      - hdl/mul_pkg.sv
      - hdl/mul_apb_decode.sv
      - hdl/booth_mult_exec.sv
      - hdl/mul_result_regs.sv
      - hdl/mul_apb_top.sv

  # testbench
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_mul_apb.sv

//--- hdl/booth_mult_exec.sv
`timescale 1ns/1ps

module booth_mult_exec #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           start,
	input  logic [DATA_WIDTH-1:0]          mcand,
	input  logic [DATA_WIDTH-1:0]          mplier,
	output logic                           prod_valid,
	output logic signed [2*DATA_WIDTH-1:0] product
);
	import mul_pkg::*;

	// product width, group count (last group may be short) and group digit width
	localparam int PW = 2 * DATA_WIDTH;
	localparam int NUM_GROUPS = (DATA_WIDTH + group_bits - 1) / group_bits;
	localparam int DIG_W = group_bits + 1;

	logic [DATA_WIDTH:0]     mplier_ext;
	logic signed [1:0]       booth_dig [DATA_WIDTH];
	logic signed [DIG_W-1:0] grp_dig [NUM_GROUPS];
	logic signed [PW-1:0]    mcand_ext;
	logic signed [PW-1:0]    pp_q [NUM_GROUPS];
	logic                    s1_valid;
	logic signed [PW-1:0]    pp_sum;

	// signed multiple of the multiplicand for one group digit
	// magnitude from shifts and adds, sign applied at the end
	function automatic logic signed [PW-1:0] sel_multiple(
		input logic signed [DIG_W-1:0] dig,
		input logic signed [PW-1:0]    m
	);
		logic [DIG_W-1:0]     mag;
		logic signed [PW-1:0] mult;
		mag = (dig < 0) ? -dig : dig;
		case (mag)
			0:       mult = '0;
			1:       mult = m;
			2:       mult = m <<< 1;
			3:       mult = (m <<< 1) + m;
			4:       mult = m <<< 2;
			5:       mult = (m <<< 2) + m;
			6:       mult = (m <<< 2) + (m <<< 1);
			7:       mult = (m <<< 3) - m;
			8:       mult = m <<< 3;
			9:       mult = (m <<< 3) + m;
			10:      mult = (m <<< 3) + (m <<< 1);
			11:      mult = (m <<< 3) + (m <<< 1) + m;
			12:      mult = (m <<< 3) + (m <<< 2);
			13:      mult = (m <<< 3) + (m <<< 2) + m;
			14:      mult = (m <<< 4) - (m <<< 1);
			15:      mult = (m <<< 4) - m;
			16:      mult = m <<< 4;
			default: mult = '0;
		endcase
		return (dig < 0) ? -mult : mult;
	endfunction

	// implicit zero below bit 0
	assign mplier_ext = {mplier, 1'b0};
	// sign-extend so every multiple is a full-width signed value
	assign mcand_ext = {{DATA_WIDTH{mcand[DATA_WIDTH-1]}}, mcand};

	// radix-2 booth, pair {b[i], b[i-1]}: 01 -> +1, 10 -> -1
	always_comb begin
		for (int i = 0; i < DATA_WIDTH; i++) begin
			case (mplier_ext[i +: 2])
				2'b01:   booth_dig[i] = 2'sb01;
				2'b10:   booth_dig[i] = 2'sb11;
				default: booth_dig[i] = 2'sb00;
			endcase
		end
	end

	// weight each run of group_bits digits into one radix-32 digit
	always_comb begin
		logic signed [DIG_W-1:0] term;
		for (int g = 0; g < NUM_GROUPS; g++) begin
			grp_dig[g] = '0;
			for (int k = 0; k < group_bits; k++) begin
				// short top group when the width is not a multiple of five
				if (g * group_bits + k < DATA_WIDTH) begin
					term = booth_dig[g * group_bits + k];
					grp_dig[g] = grp_dig[g] + (term <<< k);
				end
			end
		end
	end

	// stage 1, partial products shifted to their group position
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int g = 0; g < NUM_GROUPS; g++)
				pp_q[g] <= '0;
		end else if (start) begin
			for (int g = 0; g < NUM_GROUPS; g++)
				pp_q[g] <= sel_multiple(grp_dig[g], mcand_ext) <<< (g * group_bits);
		end
	end

	// adder tree across the registered partial products
	always_comb begin
		pp_sum = '0;
		for (int g = 0; g < NUM_GROUPS; g++)
			pp_sum = pp_sum + pp_q[g];
	end

	// valid bits follow the data through both stages
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid   <= 1'b0;
			prod_valid <= 1'b0;
		end else begin
			s1_valid   <= start;
			prod_valid <= s1_valid;
		end
	end

	// stage 2, final sum
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			product <= '0;
		else if (s1_valid)
			product <= pp_sum;
	end

endmodule

//--- hdl/mul_apb_decode.sv
`timescale 1ns/1ps

module mul_apb_decode #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [mul_pkg::apb_addr_width-1:0] paddr,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [DATA_WIDTH-1:0]             pwdata,
	input  logic                              busy,
	input  logic                              done,
	input  logic [DATA_WIDTH-1:0]             res_lo,
	input  logic [DATA_WIDTH-1:0]             res_hi,
	output logic [DATA_WIDTH-1:0]             prdata,
	output logic                              pready,
	output logic                              pslverr,
	output logic                              start,
	output logic [DATA_WIDTH-1:0]             mcand,
	output logic [DATA_WIDTH-1:0]             mplier
);
	import mul_pkg::*;

	logic                  access;
	logic                  hit_mcand;
	logic                  hit_mplier;
	logic                  hit_ro;
	logic                  mapped;
	logic [DATA_WIDTH-1:0] mplier_q;
	logic [DATA_WIDTH-1:0] status_word;

	// access phase, the only cycle a transfer takes
	assign access = psel & penable;

	// address decode against the register map
	assign hit_mcand  = (paddr == reg_mcand);
	assign hit_mplier = (paddr == reg_mplier);
	// status and both result words can only be read
	assign hit_ro     = (paddr == reg_status) | (paddr == reg_res_lo) | (paddr == reg_res_hi);
	assign mapped     = hit_mcand | hit_mplier | hit_ro;

	// zero wait states
	assign pready = 1'b1;

	// unmapped offset, write to a read-only word, or new multiplier while busy
	assign pslverr = access & (~mapped | (pwrite & hit_ro) | (pwrite & hit_mplier & busy));

	// accepted multiplier write kicks the pipeline for one cycle
	assign start = access & pwrite & hit_mplier & ~busy;

	// operand goes straight from the bus, stage 1 samples it with start
	assign mplier = pwdata;

	// operand registers, both readable by the host
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mcand    <= '0;
			mplier_q <= '0;
		end else begin
			if (access & pwrite & hit_mcand)
				mcand <= pwdata;
			// a refused write leaves the last multiplier in place
			if (start)
				mplier_q <= pwdata;
		end
	end

	// status word, flags at their package positions
	always_comb begin
		status_word = '0;
		status_word[status_busy_bit] = busy;
		status_word[status_done_bit] = done;
	end

	// read mux, data returned in the same access phase
	always_comb begin
		prdata = '0;
		if (psel & ~pwrite) begin
			case (paddr)
				reg_mcand:  prdata = mcand;
				reg_mplier: prdata = mplier_q;
				reg_status: prdata = status_word;
				reg_res_lo: prdata = res_lo;
				reg_res_hi: prdata = res_hi;
				default:    prdata = '0;
			endcase
		end
	end

endmodule

//--- hdl/mul_apb_top.sv
`timescale 1ns/1ps

module mul_apb_top #(
	parameter int DATA_WIDTH = mul_pkg::data_width_def
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [mul_pkg::apb_addr_width-1:0] paddr,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [DATA_WIDTH-1:0]             pwdata,
	output logic [DATA_WIDTH-1:0]             prdata,
	output logic                              pready,
	output logic                              pslverr
);

	// decode to execute and result
	logic                           start;
	logic [DATA_WIDTH-1:0]          mcand;
	logic [DATA_WIDTH-1:0]          mplier;
	// execute to result
	logic                           prod_valid;
	logic signed [2*DATA_WIDTH-1:0] product;
	// result back to decode
	logic                           busy;
	logic                           done;
	logic [DATA_WIDTH-1:0]          res_lo;
	logic [DATA_WIDTH-1:0]          res_hi;

	// apb register decoder
	mul_apb_decode #(
		.DATA_WIDTH(DATA_WIDTH)
	) i_decode (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.busy(busy), .done(done), .res_lo(res_lo), .res_hi(res_hi),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.start(start), .mcand(mcand), .mplier(mplier)
	);

	// two-stage booth multiplier
	booth_mult_exec #(
		.DATA_WIDTH(DATA_WIDTH)
	) i_exec (
		.clk(clk), .rst_n(rst_n), .start(start), .mcand(mcand), .mplier(mplier),
		.prod_valid(prod_valid), .product(product)
	);

	// product store and flags
	mul_result_regs #(
		.DATA_WIDTH(DATA_WIDTH)
	) i_result (
		.clk(clk), .rst_n(rst_n), .start(start), .prod_valid(prod_valid), .product(product),
		.busy(busy), .done(done), .res_lo(res_lo), .res_hi(res_hi)
	);

endmodule

//--- hdl/mul_pkg.sv
package mul_pkg;

	// operand width used when the top level is not overridden
	localparam int data_width_def = 32;

	// apb address bus width, enough for five word registers
	localparam int apb_addr_width = 5;

	// register map, byte offsets on word boundaries
	// multiplicand, read/write
	localparam logic [apb_addr_width-1:0] reg_mcand = 5'h00;
	// multiplier, read/write, writing it starts a product
	localparam logic [apb_addr_width-1:0] reg_mplier = 5'h04;
	// busy and done flags, read only
	localparam logic [apb_addr_width-1:0] reg_status = 5'h08;
	// low half of the signed product, read only
	localparam logic [apb_addr_width-1:0] reg_res_lo = 5'h0C;
	// high half of the signed product, read only
	localparam logic [apb_addr_width-1:0] reg_res_hi = 5'h10;

	// booth digits folded into one radix-32 group digit
	// a full group spans -16 to 16
	localparam int group_bits = 5;

	// status register bit positions
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1;

	// status register layout
	//   bit 0  busy, a product is in the pipeline
	//   bit 1  done, the result registers hold a finished product
	//   other bits read as zero

	// result registers read as zero until the first product lands
	// a multiplier write while busy is refused with pslverr

endpackage

//--- hdl/mul_result_regs.sv
`timescale 1ns/1ps

module mul_result_regs #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           start,
	input  logic                           prod_valid,
	input  logic signed [2*DATA_WIDTH-1:0] product,
	output logic                           busy,
	output logic                           done,
	output logic [DATA_WIDTH-1:0]          res_lo,
	output logic [DATA_WIDTH-1:0]          res_hi
);

	logic signed [2*DATA_WIDTH-1:0] prod_q;

	// host-visible flags
	// busy from the accepted start up to the product
	// done from the product up to the next start
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			// a new start wins over a product landing the same cycle
			if (start) begin
				busy <= 1'b1;
				done <= 1'b0;
			end else if (prod_valid) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// last finished product, reads zero out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			prod_q <= '0;
		else if (prod_valid)
			prod_q <= product;
	end

	// split into the two host words
	assign res_lo = prod_q[DATA_WIDTH-1:0];
	assign res_hi = prod_q[2*DATA_WIDTH-1:DATA_WIDTH];

endmodule

//--- testbench/mul_apb_tasks.svh
`ifndef MUL_APB_TASKS_SVH
`define MUL_APB_TASKS_SVH

// apb write, setup then access phase, called 1 ns after a rising edge
// returns the pslverr seen in the access phase and leaves the bus idle
task automatic apb_write(input logic [apb_addr_width-1:0] addr, input logic [31:0] data,
		output logic err);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = 1'b1;
	paddr = addr;
	pwdata = data;
	@(posedge clk);
	#drive_dly;
	penable = 1'b1;
	// mid-cycle sample, away from the edge where registers move
	@(negedge clk);
	err = pslverr;
	@(posedge clk);
	#drive_dly;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
endtask

// apb read, data comes back in the access phase
task automatic apb_read(input logic [apb_addr_width-1:0] addr, output logic [31:0] data,
		output logic err);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = 1'b0;
	paddr = addr;
	@(posedge clk);
	#drive_dly;
	penable = 1'b1;
	@(negedge clk);
	data = prdata;
	err = pslverr;
	@(posedge clk);
	#drive_dly;
	psel = 1'b0;
	penable = 1'b0;
endtask

// error line for a wrong value, then the run stops
task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
	$display("Fail at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
	stop_run();
endtask

task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
	assert (act === exp)
		else report_mismatch(name, exp, act);
endtask

// golden model, full-width signed product of the sign-extended operands
function automatic logic signed [63:0] ref_product(input logic signed [31:0] a,
		input logic signed [31:0] b);
	logic signed [63:0] ax;
	logic signed [63:0] bx;
	ax = a;
	bx = b;
	return ax * bx;
endfunction

`endif

//--- testbench/tb_mul_apb.sv
`timescale 1ns/1ps

module tb_mul_apb;
	import mul_pkg::*;

	localparam int data_width = 32;
	localparam time drive_dly = 1;
	// 200 random products at about 12 cycles, directed tests and margin
	localparam int cycle_limit = 4000;
	localparam int num_random = 200;
	localparam int poll_limit = 16;

	logic                      clk = 1'b0;
	logic                      rst_n;
	logic [apb_addr_width-1:0] paddr;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [data_width-1:0]     pwdata;
	logic [data_width-1:0]     prdata;
	logic                      pready;
	logic                      pslverr;
	int                        cycle_count = 0;
	int                        seed;

	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	`include "mul_apb_tasks.svh"

	mul_apb_top #(
		.DATA_WIDTH(data_width)
	) i_dut (
		.clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	// hang guard
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout, the run did not finish within %0d cycles", cycle_limit);
			stop_run();
		end
	end

	// zero wait states, pready never drops
	assert property (@(posedge clk) disable iff (!rst_n) pready)
		else report_mismatch("pready", 1, $sampled(pready));

	// slave errors only show up in an access phase
	assert property (@(posedge clk) disable iff (!rst_n) pslverr |-> (psel && penable))
		else report_mismatch("pslverr", 0, $sampled(pslverr));

	// accepted multiplier write at E0, done set at E2 and sampled high one edge on
	assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable && pwrite && paddr == reg_mplier && !pslverr) |-> ##3 i_dut.done)
		else report_mismatch("done", 1, $sampled(i_dut.done));

	// register map walk order
	function automatic logic [apb_addr_width-1:0] map_addr(input int idx);
		case (idx)
			0: return reg_mcand;
			1: return reg_mplier;
			2: return reg_status;
			3: return reg_res_lo;
			default: return reg_res_hi;
		endcase
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
		#drive_dly;
	endtask

	// read a register, expect no slave error and the given value
	task automatic read_check(input logic [apb_addr_width-1:0] addr, input logic [31:0] exp,
			input string name);
		logic [31:0] rd;
		logic        err;
		apb_read(addr, rd, err);
		check_value("pslverr", 0, err);
		check_value(name, exp, rd);
	endtask

	// poll STATUS until done, bounded
	task automatic wait_done();
		logic [31:0] st;
		logic        err;
		int          polls;
		polls = 0;
		st = '0;
		while (!st[status_done_bit]) begin
			if (polls == poll_limit) begin
				$display("done never came up after %0d status reads", polls);
				stop_run();
			end else begin
				apb_read(reg_status, st, err);
				polls++;
			end
		end
		check_value("status busy", 0, st[status_busy_bit]);
	endtask

	// one full product through the host interface
	task automatic run_product(input logic [31:0] a, input logic [31:0] b);
		logic               err;
		logic signed [63:0] exp;
		exp = ref_product(a, b);
		apb_write(reg_mcand, a, err);
		check_value("pslverr", 0, err);
		apb_write(reg_mplier, b, err);
		check_value("pslverr", 0, err);
		wait_done();
		read_check(reg_res_lo, exp[31:0], "res_lo");
		read_check(reg_res_hi, exp[63:32], "res_hi");
	endtask

	initial begin
		logic [31:0]        a;
		logic [31:0]        b;
		logic [31:0]        c;
		logic [31:0]        rd;
		logic [31:0]        snap [5];
		logic               err;
		logic signed [63:0] exp;
		seed = 32'hbe236402;
		rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		repeat (5) @(posedge clk);
		#drive_dly;
		rst_n = 1'b1;

		// everything reads zero out of reset
		for (int i = 0; i < 5; i++)
			read_check(map_addr(i), 32'h0, "prdata");

		// directed corners
		run_product(32'h0, 32'h1234_5678);
		run_product(32'hdead_beef, 32'h0);
		run_product(32'h1, 32'hffff_ffff);
		run_product(32'hffff_ffff, 32'hffff_ffff);
		run_product(32'h8000_0000, 32'h8000_0000);
		run_product(32'h7fff_ffff, 32'h8000_0000);
		for (int i = 0; i < 32; i += 3)
			run_product(32'h1 << i, 32'h1 << (31 - i));
		run_product(32'h5555_5555, 32'haaaa_aaaa);
		run_product(32'haaaa_aaaa, 32'haaaa_aaaa);

		// random pairs with the fixed two-cycle done timing
		for (int n = 0; n < num_random; n++) begin
			a = $random(seed);
			b = $random(seed);
			exp = ref_product(a, b);
			apb_write(reg_mcand, a, err);
			apb_write(reg_mplier, b, err);
			check_value("pslverr", 0, err);
			// one idle cycle puts the status access phase past E2
			idle_cycles(1);
			apb_read(reg_status, rd, err);
			assert (rd[status_done_bit])
				else report_mismatch("status done", 1, rd[status_done_bit]);
			read_check(reg_res_lo, exp[31:0], "res_lo");
			read_check(reg_res_hi, exp[63:32], "res_hi");
		end

		// back-to-back multiplier write hits the busy interlock
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		exp = ref_product(a, b);
		apb_write(reg_mcand, a, err);
		apb_write(reg_mplier, b, err);
		check_value("pslverr", 0, err);
		apb_write(reg_mplier, c, err);
		check_value("pslverr", 1, err);
		wait_done();
		read_check(reg_res_lo, exp[31:0], "res_lo");
		read_check(reg_res_hi, exp[63:32], "res_hi");
		read_check(reg_mplier, b, "mplier");

		// bad accesses get pslverr and change nothing
		for (int i = 0; i < 5; i++)
			apb_read(map_addr(i), snap[i], err);
		apb_read(5'h14, rd, err);
		check_value("pslverr", 1, err);
		apb_write(5'h18, $random(seed), err);
		check_value("pslverr", 1, err);
		apb_write(5'h02, $random(seed), err);
		check_value("pslverr", 1, err);
		for (int i = 2; i < 5; i++) begin
			apb_write(map_addr(i), $random(seed), err);
			check_value("pslverr", 1, err);
		end
		for (int i = 0; i < 5; i++)
			read_check(map_addr(i), snap[i], "prdata");

		// operand readback and final flags
		read_check(reg_mcand, a, "mcand");
		read_check(reg_mplier, b, "mplier");
		read_check(reg_status, 32'h1 << status_done_bit, "status");

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+testbench
hdl/mul_pkg.sv
hdl/mul_apb_decode.sv
hdl/booth_mult_exec.sv
hdl/mul_result_regs.sv
hdl/mul_apb_top.sv
testbench/tb_mul_apb.sv
